//--- Bender.yml
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - dcache/dcache_array.sv
  - dcache/dcache_ctrl.sv
  - dcache/dcache_top.sv
  - target: test
    files:
      - tests/dcache_asserts.sv
      - tests/dcache_tb.sv

//--- common/dcache_pkg.sv
`default_nettype none

// shared types and widths for the data cache
package dcache_pkg;

  // cpu and memory word size
  localparam int WORD_W = 32;

  // byte address width on both ports
  localparam int ADDR_W = 32;

  // two words per block, so one word-select bit
  localparam int WORDS_PER_BLOCK = 2;

  // byte offset inside a word is below this bit
  localparam int OFFSET_LSB = 2;

  typedef logic [WORD_W-1:0] word_t; // one data word
  typedef logic [ADDR_W-1:0] addr_t; // one byte address

  // controller states
  // WB0/WB1 write the dirty victim back, FETCH0/FETCH1 pull the new block,
  // FLUSH walks every word of every set, FLUSH_DONE is terminal
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    WB0        = 3'd1,
    WB1        = 3'd2,
    FETCH0     = 3'd3,
    FETCH1     = 3'd4,
    FLUSH      = 3'd5,
    FLUSH_DONE = 3'd6
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- dcache/dcache_array.sv
`timescale 1ns/100ps
`default_nettype none

// two ways x SETS rows, each row holds tag, two words, valid and dirty
// one lru bit per set names the way to evict next
module dcache_array #(
  parameter int SETS = 8
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                cpu_ren,
  input  logic                cpu_wen,
  input  dcache_pkg::addr_t   cpu_addr,
  input  dcache_pkg::word_t   cpu_store,
  output logic                hit,
  output logic                hit_way,
  output logic                victim_dirty,
  output logic [TAG_W-1:0]    victim_tag,
  output dcache_pkg::word_t   victim_word,
  input  logic                fill_en,
  input  logic                fill_word,
  input  logic                fill_last,
  input  logic                wb_clean,
  input  dcache_pkg::word_t   fill_data,
  input  logic [IDX_W-1:0]    flush_set,
  input  logic                flush_way,
  input  logic                flush_word,
  output logic                flush_dirty,
  output logic [TAG_W-1:0]    flush_tag,
  output dcache_pkg::word_t   flush_word_data,
  output dcache_pkg::word_t   cpu_load
);

  localparam int IDX_W   = $clog2(SETS);
  localparam int IDX_LSB = dcache_pkg::OFFSET_LSB + $clog2(dcache_pkg::WORDS_PER_BLOCK);
  localparam int TAG_W   = dcache_pkg::ADDR_W - IDX_LSB - IDX_W;

  // payload storage
  logic [TAG_W-1:0]  tag_q  [2][SETS];
  dcache_pkg::word_t data_q [2][SETS][dcache_pkg::WORDS_PER_BLOCK];
  // control bits
  logic [1:0][SETS-1:0] valid_q;
  logic [1:0][SETS-1:0] dirty_q;
  logic [SETS-1:0]      lru_q;   // 1 = evict way 1

  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;
  logic             req_word;
  logic [1:0]       way_hit;
  logic             victim;      // lru way of the request set

  // address split
  assign req_idx  = cpu_addr[IDX_LSB +: IDX_W];
  assign req_tag  = cpu_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
  assign req_word = cpu_addr[dcache_pkg::OFFSET_LSB];

  // tag compare on both ways, only for a live request
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag)
                   && (cpu_ren || cpu_wen);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];                            // way 0 unless way 1 matched
  assign cpu_load = data_q[hit_way][req_idx][req_word];    // combinational read

  // victim view for the controller
  assign victim       = lru_q[req_idx];
  assign victim_dirty = valid_q[victim][req_idx] && dirty_q[victim][req_idx];
  assign victim_tag   = tag_q[victim][req_idx];
  assign victim_word  = data_q[victim][req_idx][fill_word]; // word picked by ctrl

  // flush view, set/way/word from the flush counter
  assign flush_dirty     = valid_q[flush_way][flush_set] && dirty_q[flush_way][flush_set];
  assign flush_tag       = tag_q[flush_way][flush_set];
  assign flush_word_data = data_q[flush_way][flush_set][flush_word];

  // tag and data writes
  always_ff @(posedge CLK) begin
    if (fill_en) begin
      data_q[victim][req_idx][fill_word] <= fill_data; // word from memory
      tag_q[victim][req_idx]             <= req_tag;
    end else if (cpu_wen && hit) begin
      data_q[hit_way][req_idx][req_word] <= cpu_store; // write hit
    end
  end

  // valid, dirty and lru bits
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (fill_en) begin
        // block stays invalid until its last word lands
        valid_q[victim][req_idx] <= fill_last;
        dirty_q[victim][req_idx] <= 1'b0;
      end else if (wb_clean) begin
        dirty_q[victim][req_idx] <= 1'b0; // victim is now in memory
      end else if (hit) begin
        lru_q[req_idx] <= ~hit_way;       // other way becomes the victim
        if (cpu_wen) begin
          dirty_q[hit_way][req_idx] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// cache controller
// handles misses (optional writeback then two-word fetch) and the halt flush
module dcache_ctrl #(
  parameter int SETS = 8
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                cpu_ren,
  input  logic                cpu_wen,
  input  dcache_pkg::addr_t   cpu_addr,
  input  logic                halt,
  // from the array
  input  logic                hit,
  input  logic                victim_dirty,
  input  logic [TAG_W-1:0]    victim_tag,
  input  dcache_pkg::word_t   victim_word,
  input  logic                flush_dirty,
  input  logic [TAG_W-1:0]    flush_tag,
  input  dcache_pkg::word_t   flush_word_data,
  // to the array
  output logic                fill_en,
  output logic                fill_word,
  output logic                fill_last,
  output logic                wb_clean,
  output dcache_pkg::word_t   fill_data,
  output logic [IDX_W-1:0]    flush_set,
  output logic                flush_way,
  output logic                flush_word,
  // cpu status and memory port
  output logic                flushed,
  output logic                mem_ren,
  output logic                mem_wen,
  output dcache_pkg::addr_t   mem_addr,
  output dcache_pkg::word_t   mem_store,
  input  dcache_pkg::word_t   mem_load,
  input  logic                mem_wait
);

  localparam int IDX_W   = $clog2(SETS);
  localparam int IDX_LSB = dcache_pkg::OFFSET_LSB + $clog2(dcache_pkg::WORDS_PER_BLOCK);
  localparam int TAG_W   = dcache_pkg::ADDR_W - IDX_LSB - IDX_W;
  localparam int FC_W    = IDX_W + 2; // {set, way, word}

  dcache_pkg::ctrl_state_t state, next_state;

  logic [FC_W-1:0]  flush_cnt;
  logic             flush_step;     // current flush word is finished
  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;

  // word-aligned byte address from tag, set and word select
  function automatic dcache_pkg::addr_t mk_addr(input logic [TAG_W-1:0] t,
                                                input logic [IDX_W-1:0] i,
                                                input logic             w);
    dcache_pkg::addr_t a;
    a                           = '0;
    a[dcache_pkg::ADDR_W-1 -: TAG_W] = t;
    a[IDX_LSB +: IDX_W]         = i;
    a[dcache_pkg::OFFSET_LSB]   = w;
    return a;
  endfunction

  assign req_idx = cpu_addr[IDX_LSB +: IDX_W];
  assign req_tag = cpu_addr[dcache_pkg::ADDR_W-1 -: TAG_W];

  // second word of the block in WB1 and FETCH1
  assign fill_word = (state == dcache_pkg::WB1) || (state == dcache_pkg::FETCH1);
  assign fill_data = mem_load;           // memory word goes straight into the array

  assign flush_word = flush_cnt[0];
  assign flush_way  = flush_cnt[1];
  assign flush_set  = flush_cnt[FC_W-1:2];
  // clean words skip the memory, dirty ones wait for the write
  assign flush_step = (state == dcache_pkg::FLUSH) && (!flush_dirty || !mem_wait);
  assign flushed    = (state == dcache_pkg::FLUSH_DONE);

  // next state
  always_comb begin
    next_state = state; // hold while mem_wait is high
    case (state)
      dcache_pkg::IDLE: begin
        if (halt) begin
          next_state = dcache_pkg::FLUSH;
        end else if ((cpu_ren || cpu_wen) && !hit) begin
          next_state = victim_dirty ? dcache_pkg::WB0 : dcache_pkg::FETCH0;
        end
      end
      dcache_pkg::WB0:    if (!mem_wait) next_state = dcache_pkg::WB1;
      dcache_pkg::WB1:    if (!mem_wait) next_state = dcache_pkg::FETCH0;
      dcache_pkg::FETCH0: if (!mem_wait) next_state = dcache_pkg::FETCH1;
      dcache_pkg::FETCH1: if (!mem_wait) next_state = dcache_pkg::IDLE; // block valid now
      dcache_pkg::FLUSH: begin
        if (flush_step && (flush_cnt == '1)) begin
          next_state = dcache_pkg::FLUSH_DONE; // last word of last set done
        end
      end
      dcache_pkg::FLUSH_DONE: next_state = dcache_pkg::FLUSH_DONE; // stays for good
      default: next_state = dcache_pkg::IDLE;
    endcase
  end

  // memory port and array write strobes
  always_comb begin
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    mem_addr  = mk_addr(req_tag, req_idx, fill_word);
    mem_store = victim_word;
    fill_en   = 1'b0;
    fill_last = 1'b0;
    wb_clean  = 1'b0;
    case (state)
      dcache_pkg::WB0, dcache_pkg::WB1: begin
        mem_wen  = 1'b1;
        mem_addr = mk_addr(victim_tag, req_idx, fill_word); // old block's address
        wb_clean = (state == dcache_pkg::WB1) && !mem_wait;
      end
      dcache_pkg::FETCH0, dcache_pkg::FETCH1: begin
        mem_ren   = 1'b1;
        fill_en   = !mem_wait;                      // load is valid this cycle
        fill_last = (state == dcache_pkg::FETCH1);
      end
      dcache_pkg::FLUSH: begin
        mem_wen   = flush_dirty;                    // only dirty words go out
        mem_addr  = mk_addr(flush_tag, flush_set, flush_word);
        mem_store = flush_word_data;
      end
      default: ;
    endcase
  end

  // state and flush counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= dcache_pkg::IDLE;
      flush_cnt <= '0;
    end else begin
      state <= next_state;
      if (flush_step) begin
        flush_cnt <= flush_cnt + 1'b1; // word, then way, then set
      end
    end
  end

endmodule

`default_nettype wire

//--- dcache/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

// two-way write-back data cache between cpu data port and word memory
module dcache_top #(
  parameter int SETS = 8 // number of sets, power of two
) (
  input  logic               CLK,
  input  logic               nRST,
  // cpu side
  input  logic               cpu_ren,
  input  logic               cpu_wen,
  input  logic               halt,
  input  dcache_pkg::addr_t  cpu_addr,
  input  dcache_pkg::word_t  cpu_store,
  output logic               hit,
  output logic               flushed,
  output dcache_pkg::word_t  cpu_load,
  // memory side
  output logic               mem_ren,
  output logic               mem_wen,
  output dcache_pkg::addr_t  mem_addr,
  output dcache_pkg::word_t  mem_store,
  input  dcache_pkg::word_t  mem_load,
  input  logic               mem_wait
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_LSB
                         - $clog2(dcache_pkg::WORDS_PER_BLOCK) - IDX_W;

  logic              victim_dirty;    // lru way of request set needs writeback
  logic [TAG_W-1:0]  victim_tag;
  dcache_pkg::word_t victim_word;     // victim word picked by fill_word
  logic              fill_en, fill_word, fill_last, wb_clean;
  dcache_pkg::word_t fill_data;
  logic [IDX_W-1:0]  flush_set;
  logic              flush_way, flush_word;
  logic              flush_dirty;
  logic [TAG_W-1:0]  flush_tag;
  dcache_pkg::word_t flush_word_data;

  // storage, lookup and cpu write hits
  dcache_array #(.SETS(SETS)) array0 (
    .CLK, .nRST,
    .cpu_ren, .cpu_wen, .cpu_addr, .cpu_store,
    .hit,
    .hit_way         (), // only steers the read mux and lru inside the array
    .victim_dirty, .victim_tag, .victim_word,
    .fill_en, .fill_word, .fill_last, .wb_clean, .fill_data,
    .flush_set, .flush_way, .flush_word,
    .flush_dirty, .flush_tag, .flush_word_data,
    .cpu_load
  );

  // miss / writeback / flush sequencing and memory port
  dcache_ctrl #(.SETS(SETS)) ctrl0 (
    .CLK, .nRST,
    .cpu_ren, .cpu_wen, .cpu_addr, .halt,
    .hit, .victim_dirty, .victim_tag, .victim_word,
    .flush_dirty, .flush_tag, .flush_word_data,
    .fill_en, .fill_word, .fill_last, .wb_clean, .fill_data,
    .flush_set, .flush_way, .flush_word,
    .flushed, .mem_ren, .mem_wen, .mem_addr, .mem_store,
    .mem_load, .mem_wait
  );

endmodule

`default_nettype wire

//--- files.f
common/dcache_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

//--- tests/dcache_asserts.sv
`timescale 1ns/100ps
`default_nettype none

// port rules of the cache, bound into every dcache_top
module dcache_asserts (
  input logic CLK,
  input logic nRST,
  input logic cpu_ren,
  input logic cpu_wen,
  input logic hit,
  input logic flushed,
  input logic mem_ren,
  input logic mem_wen
);

  int fails = 0; // number of failed port rules

  mem_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
    else begin
      fails++;
      $error("mem_ren and mem_wen are high together");
    end

  // flushed is terminal
  flushed_stays: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else begin
      fails++;
      $error("flushed fell after it was raised");
    end

  hit_has_req: assert property (@(posedge CLK) disable iff (!nRST) hit |-> (cpu_ren || cpu_wen))
    else begin
      fails++;
      $error("hit is high with no cpu request");
    end

endmodule

bind dcache_top dcache_asserts asserts0 (
  .CLK, .nRST, .cpu_ren, .cpu_wen, .hit, .flushed, .mem_ren, .mem_wen
);

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

// trace driven testbench for the two-way write-back data cache
module tb_dcache;

  localparam int SETS = 8;

  logic              CLK;
  logic              nRST;
  logic              cpu_ren, cpu_wen, halt;
  dcache_pkg::addr_t cpu_addr;
  dcache_pkg::word_t cpu_store;
  logic              hit, flushed;
  dcache_pkg::word_t cpu_load;
  logic              mem_ren, mem_wen;
  dcache_pkg::addr_t mem_addr;
  dcache_pkg::word_t mem_store, mem_load;
  logic              mem_wait;

  dcache_pkg::word_t mem_q [dcache_pkg::addr_t];      // words the dut wrote back
  bit                cpu_blocks [dcache_pkg::addr_t]; // block addresses the trace stored to
  byte               ops [$];                         // trace operation letters
  dcache_pkg::addr_t addrs [$];
  dcache_pkg::word_t vals [$];
  int                n_checks = 0;
  int                n_errors = 0;
  int                cycles = 0;
  int                limit = 0;       // 0 until the trace is loaded
  bit                mem_busy = 0;    // a transfer is being stretched
  int                wait_left = 0;

  dcache_top #(.SETS(SETS)) dut0 (
    .CLK, .nRST,
    .cpu_ren, .cpu_wen, .halt, .cpu_addr, .cpu_store,
    .hit, .flushed, .cpu_load,
    .mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // unwritten memory holds a pattern made from the whole address
  function automatic dcache_pkg::word_t mem_read(input dcache_pkg::addr_t a);
    if (mem_q.exists(a)) begin
      return mem_q[a];
    end
    return a ^ 32'hA5A5_0000;
  endfunction

  task automatic check_value(input string name, input dcache_pkg::addr_t a,
                             input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("[FAIL] %s at addr %h: expected %h, got %h", name, a, exp, got);
    end
  endtask

  task automatic check_cond(input bit cond, input string what);
    n_checks++;
    assert (cond) else begin
      n_errors++;
      $display("%s", what);
    end
  endtask

  // memory model with mem_wait high in the first cycle of a transfer and 0..3 cycles more
  initial begin
    void'($urandom(32'h1638));        // single seed for every wait state of the run
    forever begin
      @(posedge CLK);
      if (mem_ren || mem_wen) begin
        if (!mem_wait) begin
          if (mem_wen) begin
            check_cond(cpu_blocks.exists(mem_addr & ~32'h7), // two words per block
                       $sformatf("memory write to %h, a block the CPU never wrote", mem_addr));
            mem_q[mem_addr] = mem_store;
          end
          mem_wait <= 1'b1;           // transfer taken, stall the next one
          mem_busy = 1'b0;
        end else begin
          if (!mem_busy) begin
            mem_busy  = 1'b1;
            wait_left = $urandom % 4;
          end else begin
            wait_left--;
          end
          if (wait_left == 0) begin
            mem_wait <= 1'b0;
            mem_load <= mem_read(mem_addr); // valid in the cycle mem_wait is low
          end
        end
      end
    end
  end

  // run limit from the trace length
  always @(posedge CLK) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the cache did not answer within %0d cycles", limit);
      $display("checks %0d, errors %0d", n_checks, n_errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  task automatic load_trace();
    int fd;
    int ch;
    int n;
    byte op;
    dcache_pkg::addr_t a;
    dcache_pkg::word_t d;
    fd = $fopen("tests/dcache_trace.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("cannot open the trace file tests/dcache_trace.txt");
    end else begin
      while ($fscanf(fd, " %c", op) == 1) begin
        a = '0;
        d = '0;
        n = 0;
        if (op == "#") begin
          ch = $fgetc(fd);             // skip the comment line
          while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          if (op == "N") begin
            n = $fscanf(fd, "%h", a);
            check_cond(n == 1, "an N line of the trace has no address");
          end else if (op != "H") begin
            n = $fscanf(fd, "%h %h", a, d);
            check_cond(n == 2, $sformatf("a %c line of the trace lacks its address or value", op));
          end
          ops.push_back(op);
          addrs.push_back(a);
          vals.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  // hold the request until hit is seen at a rising edge
  task automatic cpu_access(input bit ren, input bit wen, input dcache_pkg::addr_t a,
                            input dcache_pkg::word_t d);
    cpu_ren   <= ren;
    cpu_wen   <= wen;
    cpu_addr  <= a;
    cpu_store <= d;
    do begin
      @(posedge CLK);
    end while (!hit);
  endtask

  // read that must hit in its first cycle with no memory read
  task automatic hit_probe(input dcache_pkg::addr_t a);
    cpu_ren  <= 1'b1;
    cpu_wen  <= 1'b0;
    cpu_addr <= a;
    @(posedge CLK);
    check_value("hit", a, hit, 32'h1);
    check_value("mem_ren", a, mem_ren, 32'h0);
    while (!hit) begin
      @(posedge CLK);
    end
  endtask

  initial begin
    nRST      = 1'b0;
    cpu_ren   = 1'b0;
    cpu_wen   = 1'b0;
    halt      = 1'b0;
    cpu_addr  = '0;
    cpu_store = '0;
    mem_load  = '0;
    mem_wait  = 1'b1;
    load_trace();
    check_cond(ops.size() > 0, "the trace file holds no operations");
    limit = ops.size() * 40 + SETS * 4 * 5 + 100;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    foreach (ops[i]) begin
      case (ops[i])
        "R": begin
          cpu_access(1'b1, 1'b0, addrs[i], '0);
          check_value("cpu_load", addrs[i], cpu_load, vals[i]);
        end
        "W": begin
          cpu_blocks[addrs[i] & ~32'h7] = 1'b1;
          cpu_access(1'b0, 1'b1, addrs[i], vals[i]);
        end
        "N": hit_probe(addrs[i]);
        "H": begin
          cpu_ren <= 1'b0;
          cpu_wen <= 1'b0;
          halt    <= 1'b1;                 // held high from here on
          do begin
            @(posedge CLK);
          end while (!flushed);
        end
        "C": check_value("memory", addrs[i], mem_read(addrs[i]), vals[i]);
        default: check_cond(1'b0, $sformatf("unknown trace operation %c", ops[i]));
      endcase
    end
    n_errors += dut0.asserts0.fails;       // bound port assertions
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/dcache_trace.txt
# op address value  (R: expected load, W: store data, C: expected memory word after flush)
# N: read that must hit without a memory read, H: halt and wait for flushed
# set 0, a read miss fills both words of the block
R 00000100 a5a50100
R 00000104 a5a50104
# write hit, then read back
W 00000104 11112222
R 00000104 11112222
# set 1, the third tag evicts the dirty block, which is read back from memory
W 00000408 deadbeef
R 00000808 a5a50808
R 00000c08 a5a50c08
R 0000040c a5a5040c
R 00000408 deadbeef
# set 2, a re-read of A makes B the victim of C
R 00001010 a5a51010
R 00002010 a5a52010
R 00001010 a5a51010
R 00003010 a5a53010
N 00001010
N 00003010
R 00002010 a5a52010
# set 3 with both ways dirty, and a second store to set 0
W 00005018 cafef00d
W 0000601c 0badc0de
W 00000100 33334444
R 00000100 33334444
H
C 00000100 33334444
C 00000104 11112222
C 00000408 deadbeef
C 0000040c a5a5040c
C 00005018 cafef00d
C 0000501c a5a5501c
C 00006018 a5a56018
C 0000601c 0badc0de
C 00001010 a5a51010
